//--- alu.sv
// ALU
// Combinational result for Z from Y (a) and the bus (b); incPc forces b+1
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
        input  word_t  a,
        input  word_t  b,
        input  aluOp_e op,
        input  logic   incPc,
        output word_t  result
);

        logic [4:0] shamt;

        assign shamt = b[4:0];

        always_comb begin
                if (incPc) begin
                        result = b + 32'd1;
                end else begin
                        case (op)
                                opAdd: result = a + b;
                                opSub: result = a - b;
                                opAnd: result = a & b;
                                opOr:  result = a | b;
                                opShr: result = a >> shamt;
                                opShl: result = a << shamt;
                                // Unary ops work on the bus operand
                                opNeg: result = '0 - b;
                                opNot: result = ~b;
                                opNop: result = b;
                                default: result = b;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- build.f
cpuPkg.sv
busIf.sv
alu.sv
registerFile.sv
conditionLogic.sv
memoryUnit.sv
datapathCore.sv
cpuDatapath.sv
tb_cpuDatapath.sv

//--- busIf.sv
// Internal bus bundle
// Carries the shared bus, the IR word and the words that feed the bus
// multiplexer, plus the condition flag
`timescale 1ns/1ps
`default_nettype none

interface busIf import cpuPkg::*; ();

        word_t busValue;
        word_t irWord;
        word_t regValue;
        word_t mdrValue;
        logic  conFlag;

        modport core (
                output busValue, irWord,
                input  regValue, mdrValue, conFlag
        );

        modport regs (input busValue, irWord, output regValue);

        modport cond (input busValue, irWord, output conFlag);

        modport mem (input busValue, output mdrValue);

endinterface

`default_nettype wire

//--- conditionLogic.sv
// Branch condition logic
// Tests the bus against the IR condition field and holds the result
// in the condition flip-flop until the next conIn
`timescale 1ns/1ps
`default_nettype none

module conditionLogic import cpuPkg::*; (
        input  logic clk,
        input  logic rstN,
        input  logic conIn,
        busIf.cond   bus
);

        cond_t cond;
        logic  isZero;
        logic  condMet;

        assign cond   = bus.irWord[condHi:condLo];
        assign isZero = (bus.busValue == '0);

        always_comb begin
                case (cond)
                        condZero:     condMet = isZero;
                        condNonzero:  condMet = !isZero;
                        condPositive: condMet = !bus.busValue[31] && !isZero;
                        default:      condMet = bus.busValue[31];
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        bus.conFlag <= 1'b0;
                end else if (conIn) begin
                        bus.conFlag <= condMet;
                end
        end

endmodule

`default_nettype wire

//--- cpuDatapath.sv
// Single-bus CPU datapath top level
// Joins the core, register file, condition logic and memory over one
// internal bus; control strobes come straight from the ports
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath import cpuPkg::*; #(
        parameter int memWords = 512
) (
        input  logic    clk,
        input  logic    rstN,
        input  logic    read,
        input  logic    write,
        input  logic    rIn,
        input  logic    rOut,
        input  logic    baOut,
        input  logic    gra,
        input  logic    grb,
        input  logic    grc,
        input  logic    conIn,
        input  logic    marIn,
        input  logic    mdrIn,
        input  logic    yIn,
        input  logic    zIn,
        input  logic    pcIn,
        input  logic    irIn,
        input  logic    incPc,
        input  logic    inPortIn,
        input  logic    zLowOut,
        input  logic    mdrOut,
        input  logic    pcOut,
        input  logic    inPortOut,
        input  logic    cOut,
        input  opcode_t opcode,
        input  word_t   inPortData,
        output word_t   busValue,
        output word_t   pc,
        output logic    conFlag
);

        busIf bus ();

        datapathCore u_datapathCore (
                .clk(clk), .rstN(rstN), .pcIn(pcIn), .irIn(irIn), .yIn(yIn),
                .zIn(zIn), .incPc(incPc), .inPortIn(inPortIn), .pcOut(pcOut),
                .zLowOut(zLowOut), .mdrOut(mdrOut), .inPortOut(inPortOut),
                .cOut(cOut), .rOut(rOut), .baOut(baOut), .opcode(opcode),
                .inPortData(inPortData), .pc(pc), .bus(bus.core)
        );

        registerFile u_registerFile (
                .clk(clk), .rstN(rstN), .gra(gra), .grb(grb), .grc(grc),
                .rIn(rIn), .baOut(baOut), .bus(bus.regs)
        );

        conditionLogic u_conditionLogic (
                .clk(clk), .rstN(rstN), .conIn(conIn), .bus(bus.cond)
        );

        memoryUnit #(.memWords(memWords)) u_memoryUnit (
                .clk(clk), .rstN(rstN), .marIn(marIn), .mdrIn(mdrIn),
                .read(read), .write(write), .bus(bus.mem)
        );

        assign busValue = bus.busValue;
        assign conFlag  = bus.conFlag;

endmodule

`default_nettype wire

//--- cpuPkg.sv
// CPU package
// Shared word and field types, instruction field positions, branch
// condition codes and the ALU operation encoding
`default_nettype none

package cpuPkg;

        typedef logic [31:0] word_t;
        typedef logic [3:0]  regIdx_t;
        typedef logic [4:0]  opcode_t;
        typedef logic [1:0]  cond_t;

        // Instruction fields
        localparam int raHi   = 26;
        localparam int raLo   = 23;
        localparam int rbHi   = 22;
        localparam int rbLo   = 19;
        localparam int rcHi   = 18;
        localparam int rcLo   = 15;
        localparam int condHi = 20;
        localparam int condLo = 19;
        localparam int cHi    = 18;
        localparam int cLo    = 0;

        // Branch conditions held in the low bits of the rb field
        localparam cond_t condZero     = 2'b00;
        localparam cond_t condNonzero  = 2'b01;
        localparam cond_t condPositive = 2'b10;
        localparam cond_t condNegative = 2'b11;

        typedef enum logic [4:0] {
                opNop = 5'b00000,
                opAdd = 5'b00001,
                opSub = 5'b00010,
                opShr = 5'b00101,
                opShl = 5'b00110,
                opAnd = 5'b01010,
                opOr  = 5'b01011,
                opNeg = 5'b01100,
                opNot = 5'b01111
        } aluOp_e;

        // Sign-extended constant C from an instruction word
        function automatic word_t constC(input word_t ir);
                return {{(31 - cHi){ir[cHi]}}, ir[cHi:cLo]};
        endfunction

endpackage

`default_nettype wire

//--- datapathCore.sv
// Datapath core
// PC, IR, Y, Z and the input port register around the ALU, with the
// bus multiplexer driven by one-hot out strobes
`timescale 1ns/1ps
`default_nettype none

module datapathCore import cpuPkg::*; (
        input  logic    clk,
        input  logic    rstN,
        input  logic    pcIn,
        input  logic    irIn,
        input  logic    yIn,
        input  logic    zIn,
        input  logic    incPc,
        input  logic    inPortIn,
        input  logic    pcOut,
        input  logic    zLowOut,
        input  logic    mdrOut,
        input  logic    inPortOut,
        input  logic    cOut,
        input  logic    rOut,
        input  logic    baOut,
        input  opcode_t opcode,
        input  word_t   inPortData,
        output word_t   pc,
        busIf.core      bus
);

        word_t ir;
        word_t y;
        word_t z;
        word_t inPort;
        word_t aluResult;

        alu u_alu (
                .a      (y),
                .b      (bus.busValue),
                .op     (aluOp_e'(opcode)),
                .incPc  (incPc),
                .result (aluResult)
        );

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        pc     <= '0;
                        ir     <= '0;
                        y      <= '0;
                        z      <= '0;
                        inPort <= '0;
                end else begin
                        if (pcIn)     pc     <= bus.busValue;
                        if (irIn)     ir     <= bus.busValue;
                        if (yIn)      y      <= bus.busValue;
                        if (zIn)      z      <= aluResult;
                        if (inPortIn) inPort <= inPortData;
                end
        end

        // Bus reads zero when nothing drives it
        always_comb begin
                if (pcOut) begin
                        bus.busValue = pc;
                end else if (zLowOut) begin
                        bus.busValue = z;
                end else if (mdrOut) begin
                        bus.busValue = bus.mdrValue;
                end else if (inPortOut) begin
                        bus.busValue = inPort;
                end else if (cOut) begin
                        // Branch offset only when the condition holds
                        bus.busValue = bus.conFlag ? constC(ir) : '0;
                end else if (rOut || baOut) begin
                        bus.busValue = bus.regValue;
                end else begin
                        bus.busValue = '0;
                end
        end

        assign bus.irWord = ir;

endmodule

`default_nettype wire

//--- memoryUnit.sv
// Memory unit
// MAR, MDR and a word memory loaded from a hex image at start-up.
// Reads are combinational at MAR; writes store MDR
`timescale 1ns/1ps
`default_nettype none

module memoryUnit import cpuPkg::*; #(
        parameter int memWords = 512
) (
        input  logic clk,
        input  logic rstN,
        input  logic marIn,
        input  logic mdrIn,
        input  logic read,
        input  logic write,
        busIf.mem    bus
);

        localparam int addrBits = $clog2(memWords);

        word_t               mem [memWords];
        word_t               mar;
        word_t               mdr;
        logic [addrBits-1:0] addr;

        initial begin
                $readmemh("program.hex", mem);
        end

        // Upper MAR bits are ignored
        assign addr = mar[addrBits-1:0];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        mar <= '0;
                        mdr <= '0;
                end else begin
                        if (marIn) begin
                                mar <= bus.busValue;
                        end
                        if (mdrIn) begin
                                mdr <= read ? mem[addr] : bus.busValue;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (write) begin
                        mem[addr] <= mdr;
                end
        end

        assign bus.mdrValue = mdr;

endmodule

`default_nettype wire

//--- program.hex
// One 32-bit instruction word per line, starting at address 0
// Columns: word, then the address and the instruction it encodes
93000019 // 0: brzr R6, 25
9188000A // 1: brnz R3, 10
9217FFFD // 2: brpl R4, -3
92980007 // 3: brmi R5, 7
910FFFFE // 4: brnz R2, -2
00300000 // 5: ra = R0, rb = R6, C = 0

//--- registerFile.sv
// General register file
// Sixteen 32-bit registers selected by the ra, rb or rc field of the IR.
// With baOut, register 0 reads as zero for base addressing
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
        input  logic clk,
        input  logic rstN,
        input  logic gra,
        input  logic grb,
        input  logic grc,
        input  logic rIn,
        input  logic baOut,
        busIf.regs   bus
);

        word_t   regs [16];
        regIdx_t sel;

        // Field select with gra over grb over grc
        always_comb begin
                if (gra) begin
                        sel = bus.irWord[raHi:raLo];
                end else if (grb) begin
                        sel = bus.irWord[rbHi:rbLo];
                end else if (grc) begin
                        sel = bus.irWord[rcHi:rcLo];
                end else begin
                        sel = '0;
                end
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < 16; i++) begin
                                regs[i] <= '0;
                        end
                end else if (rIn) begin
                        regs[sel] <= bus.busValue;
                end
        end

        assign bus.regValue = (baOut && sel == '0) ? '0 : regs[sel];

endmodule

`default_nettype wire

//--- tb_cpuDatapath.sv
// Testbench for the single-bus CPU datapath
// Steps fetch, branch and ALU sequences from a table and checks the bus,
// the PC and the condition flag
`timescale 1ns/1ps
`default_nettype none

module tb_cpuDatapath import cpuPkg::*; ();

        localparam int clkPeriod = 20;
        localparam int rowCount  = 20;

        typedef struct packed {
                logic    isBranch;
                word_t   instr;
                word_t   x;
                word_t   y;
                opcode_t op;
                word_t   expected;
        } row_t;

        // Strobe masks with bit positions as in the port map below
        localparam logic [21:0] onRead      = 22'd1 << 0;
        localparam logic [21:0] onRIn       = 22'd1 << 2;
        localparam logic [21:0] onROut      = 22'd1 << 3;
        localparam logic [21:0] onBaOut     = 22'd1 << 4;
        localparam logic [21:0] onGra       = 22'd1 << 5;
        localparam logic [21:0] onGrb       = 22'd1 << 6;
        localparam logic [21:0] onConIn     = 22'd1 << 8;
        localparam logic [21:0] onMarIn     = 22'd1 << 9;
        localparam logic [21:0] onMdrIn     = 22'd1 << 10;
        localparam logic [21:0] onYIn       = 22'd1 << 11;
        localparam logic [21:0] onZIn       = 22'd1 << 12;
        localparam logic [21:0] onPcIn      = 22'd1 << 13;
        localparam logic [21:0] onIrIn      = 22'd1 << 14;
        localparam logic [21:0] onIncPc     = 22'd1 << 15;
        localparam logic [21:0] onInPortIn  = 22'd1 << 16;
        localparam logic [21:0] onZLowOut   = 22'd1 << 17;
        localparam logic [21:0] onMdrOut    = 22'd1 << 18;
        localparam logic [21:0] onPcOut     = 22'd1 << 19;
        localparam logic [21:0] onInPortOut = 22'd1 << 20;
        localparam logic [21:0] onCOut      = 22'd1 << 21;

        logic        clk;
        logic        rstN;
        logic [21:0] ctrl;
        opcode_t     opcode;
        word_t       inPortData;
        word_t       busValue;
        word_t       pc;
        logic        conFlag;
        row_t        rows [rowCount];
        int          errors = 0;
        int          testErrors = 0;
        int          passed = 0;
        int          failed = 0;
        int          cycles = 0;
        int          cycleLimit = rowCount * 12 + 20;

        cpuDatapath #(.memWords(512)) u_cpuDatapath (
                .clk(clk), .rstN(rstN),
                .read(ctrl[0]), .write(ctrl[1]), .rIn(ctrl[2]), .rOut(ctrl[3]),
                .baOut(ctrl[4]), .gra(ctrl[5]), .grb(ctrl[6]), .grc(ctrl[7]),
                .conIn(ctrl[8]), .marIn(ctrl[9]), .mdrIn(ctrl[10]), .yIn(ctrl[11]),
                .zIn(ctrl[12]), .pcIn(ctrl[13]), .irIn(ctrl[14]), .incPc(ctrl[15]),
                .inPortIn(ctrl[16]), .zLowOut(ctrl[17]), .mdrOut(ctrl[18]),
                .pcOut(ctrl[19]), .inPortOut(ctrl[20]), .cOut(ctrl[21]),
                .opcode(opcode), .inPortData(inPortData),
                .busValue(busValue), .pc(pc), .conFlag(conFlag)
        );

        initial begin
                clk = 1'b0;
                forever #(clkPeriod / 2) clk = ~clk;
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles > cycleLimit) begin
                        $display("Run stopped: cycle limit of %0d reached", cycleLimit);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        task automatic compare(input word_t got, input word_t want, input string what);
                if (got !== want) begin
                        errors++;
                        testErrors++;
                        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
                end
        endtask

        // One clock step with strobes set on the falling edge and checks a quarter period later
        task automatic step(input logic [21:0] strobes, input opcode_t op, input word_t data);
                @(negedge clk);
                ctrl       = strobes;
                opcode     = op;
                inPortData = data;
                #(clkPeriod / 4);
        endtask

        task automatic endTest(input string name);
                if (testErrors == 0) begin
                        passed++;
                        $display("%s: ok", name);
                end else begin
                        failed++;
                        $display("%s: %0d mismatches", name, testErrors);
                end
                testErrors = 0;
        endtask

        task automatic fetchAt(input word_t addr, input word_t instr);
                step(onInPortIn, opNop, addr);
                step(onInPortOut | onPcIn, opNop, '0);
                step(onPcOut | onMarIn | onIncPc | onZIn, opNop, '0);
                compare(busValue, addr, "bus during T0");
                step(onZLowOut | onPcIn | onRead | onMdrIn, opNop, '0);
                step(onMdrOut | onIrIn, opNop, '0);
                compare(busValue, instr, "instruction during T2");
                compare(pc, addr + 32'd1, "pc after T1");
        endtask

        task automatic runBranch(input row_t r);
                word_t c;
                word_t target;
                logic  taken;
                c      = {{13{r.instr[18]}}, r.instr[18:0]};
                taken  = r.expected[0];
                target = r.x + 32'd1 + (taken ? c : 32'd0);
                fetchAt(r.x, r.instr);
                step(onInPortIn, opNop, r.y);
                step(onInPortOut | onGra | onRIn, opNop, '0);
                step(onGra | onROut | onConIn, opNop, '0);
                compare(busValue, r.y, "Ra on the bus");
                step(onPcOut | onYIn, opNop, '0);
                compare(busValue, r.x + 32'd1, "pc on the bus");
                step(onCOut | onZIn, opAdd, '0);
                compare({31'd0, conFlag}, {31'd0, taken}, "condition flag");
                compare(busValue, taken ? c : 32'd0, "branch offset");
                step(onZLowOut | onPcIn, opNop, '0);
                compare(busValue, target, "branch target");
                step('0, opNop, '0);
                compare(pc, target, "pc after branch");
        endtask

        task automatic runAlu(input row_t r);
                step(onInPortIn, opNop, r.x);
                step(onInPortOut | onYIn | onInPortIn, opNop, r.y);
                step(onInPortOut | onZIn, r.op, '0);
                step(onZLowOut, opNop, '0);
                compare(busValue, r.expected, "ALU result");
        endtask

        // R0 reads zero only with baOut while R6 keeps its value
        task automatic checkBaseZero();
                fetchAt(32'd5, 32'h0030_0000);
                step(onInPortIn, opNop, 32'h0000_abcd);
                step(onInPortOut | onGra | onRIn | onInPortIn, opNop, 32'h0000_600d);
                step(onInPortOut | onGrb | onRIn, opNop, '0);
                step(onGra | onBaOut, opNop, '0);
                compare(busValue, '0, "R0 with baOut");
                step(onGra | onROut, opNop, '0);
                compare(busValue, 32'h0000_abcd, "R0 with rOut");
                step(onGrb | onBaOut, opNop, '0);
                compare(busValue, 32'h0000_600d, "R6 with baOut");
        endtask

        function automatic row_t branchRow(input word_t addr, input word_t instr,
                        input word_t ra, input logic taken);
                row_t r;
                r.isBranch = 1'b1;
                r.instr    = instr;
                r.x        = addr;
                r.y        = ra;
                r.op       = opNop;
                r.expected = {31'd0, taken};
                return r;
        endfunction

        function automatic row_t aluRow(input word_t a, input word_t b, input opcode_t op,
                        input word_t result);
                row_t r;
                r.isBranch = 1'b0;
                r.instr    = '0;
                r.x        = a;
                r.y        = b;
                r.op       = op;
                r.expected = result;
                return r;
        endfunction

        initial begin
                ctrl       = '0;
                opcode     = opNop;
                inPortData = '0;
                rstN       = 1'b0;

                // Instruction words repeat program.hex
                rows[0]  = branchRow(32'd0, 32'h9300_0019, 32'd1, 1'b0);
                rows[1]  = branchRow(32'd0, 32'h9300_0019, 32'd0, 1'b1);
                rows[2]  = branchRow(32'd1, 32'h9188_000a, 32'd5, 1'b1);
                rows[3]  = branchRow(32'd1, 32'h9188_000a, 32'd0, 1'b0);
                rows[4]  = branchRow(32'd2, 32'h9217_fffd, 32'd7, 1'b1);
                rows[5]  = branchRow(32'd2, 32'h9217_fffd, 32'd0, 1'b0);
                rows[6]  = branchRow(32'd2, 32'h9217_fffd, 32'hffff_fffc, 1'b0);
                rows[7]  = branchRow(32'd3, 32'h9298_0007, 32'hffff_fff0, 1'b1);
                rows[8]  = branchRow(32'd3, 32'h9298_0007, 32'd9, 1'b0);
                rows[9]  = branchRow(32'd4, 32'h910f_fffe, 32'hffff_ffff, 1'b1);
                rows[10] = aluRow(32'd100, 32'd23, opAdd, 32'd123);
                rows[11] = aluRow(32'd100, 32'd23, opSub, 32'd77);
                rows[12] = aluRow(32'd5, 32'd8, opSub, 32'hffff_fffd);
                rows[13] = aluRow(32'hf0f0_1234, 32'h0ff0_ff00, opAnd, 32'h00f0_1200);
                rows[14] = aluRow(32'hf000_0001, 32'h0000_0f00, opOr, 32'hf000_0f01);
                rows[15] = aluRow(32'h8000_0010, 32'd4, opShr, 32'h0800_0001);
                rows[16] = aluRow(32'd3, 32'd33, opShl, 32'd6);
                rows[17] = aluRow(32'h0000_1111, 32'd5, opNeg, 32'hffff_fffb);
                rows[18] = aluRow(32'h0000_1111, 32'h0000_ffff, opNot, 32'hffff_0000);
                rows[19] = aluRow(32'h0000_1111, 32'h1234_5678, opNop, 32'h1234_5678);

                repeat (2) @(posedge clk);
                @(negedge clk);
                rstN = 1'b1;
                #(clkPeriod / 4);
                compare(pc, '0, "pc after reset");
                compare(busValue, '0, "bus after reset");
                compare({31'd0, conFlag}, '0, "condition flag after reset");
                endTest("Reset");

                for (int i = 0; i < rowCount; i++) begin
                        if (rows[i].isBranch) begin
                                runBranch(rows[i]);
                                endTest($sformatf("Row %0d branch at %0d", i, rows[i].x));
                        end else begin
                                runAlu(rows[i]);
                                endTest($sformatf("Row %0d ALU op %b", i, rows[i].op));
                        end
                end

                checkBaseZero();
                endTest("Base register zero");

                $display("%0d tests passed, %0d failed, %0d mismatches", passed, failed, errors);
                if (errors == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

`default_nettype wire
